//--- hdl/rv_exec_pkg.sv
package rv_exec_pkg;

    // depth of the downstream buffer when the top level does not override it.
    localparam int unsigned DEFAULT_OUT_CREDITS = 4;

    typedef enum logic [2:0]
    {
        class_alu            = 3'd0,
        class_alu_imm_unused = 3'd1,
        class_branch         = 3'd2,
        class_jal            = 3'd3,
        class_jalr           = 3'd4,
        class_store          = 3'd5
    } exec_class_t;

    typedef enum logic [3:0]
    {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_xor  = 4'd4,
        alu_or   = 4'd5,
        alu_and  = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_t;

    // branch codes follow the RV32I funct3 values.
    typedef enum logic [3:0]
    {
        br_beq  = 4'd0,
        br_bne  = 4'd1,
        br_blt  = 4'd4,
        br_bge  = 4'd5,
        br_bltu = 4'd6,
        br_bgeu = 4'd7
    } branch_cond_t;

    typedef enum logic [3:0]
    {
        size_byte = 4'd0,
        size_half = 4'd1,
        size_word = 4'd2
    } store_size_t;

    // the function field is read according to the operation class.
    typedef union packed
    {
        alu_op_t      alu_op;
        branch_cond_t cond;
        store_size_t  size;
    } exec_func_u;

    typedef struct packed
    {
        exec_class_t op_class;
        exec_func_u  func;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] store_data;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic        reg_write;
        logic        pred_taken;
    } exec_req_t;

    typedef struct packed
    {
        logic [31:0] value;
        logic        cond_true;
        logic [31:0] sum;
    } int_res_t;

    typedef struct packed
    {
        logic [31:0] target;
        logic [31:0] store_addr;
        logic [31:0] wdata;
        logic [3:0]  wsel;
    } addr_res_t;

    typedef struct packed
    {
        logic [31:0] result;
        logic [4:0]  rd;
        logic        reg_write;
        logic        store;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wsel;
    } exec_resp_t;

    typedef struct packed
    {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

//--- hdl/rv_exec_int_unit.sv
`timescale 1ns/1ps

module rv_exec_int_unit
(
    input  rv_exec_pkg::exec_req_t i_req,
    output rv_exec_pkg::int_res_t  o_res
);

    logic        is_alu;
    logic        is_branch;
    logic        is_store;
    logic        do_sub;
    logic [31:0] operand_b;
    logic [31:0] adder_b;
    logic [32:0] sum;
    logic        overflow;
    logic        eq;
    logic        lts;
    logic        ltu;
    logic [4:0]  shamt;
    logic        cond_met;
    logic [31:0] value;

    assign is_alu    = i_req.op_class == rv_exec_pkg::class_alu;
    assign is_branch = i_req.op_class == rv_exec_pkg::class_branch;
    assign is_store  = i_req.op_class == rv_exec_pkg::class_store;

    // branches and compares all come from op1 - op2 on the same adder.
    assign do_sub = is_branch |
                    (is_alu & ((i_req.func.alu_op == rv_exec_pkg::alu_sub) |
                               (i_req.func.alu_op == rv_exec_pkg::alu_slt) |
                               (i_req.func.alu_op == rv_exec_pkg::alu_sltu)));

    // a store adds the immediate, so sum is its effective address.
    assign operand_b = is_store ? i_req.imm : i_req.op2;
    assign adder_b   = do_sub ? ~operand_b : operand_b;
    assign sum       = {1'b0, i_req.op1} + {1'b0, adder_b} + {32'd0, do_sub};

    assign overflow = (i_req.op1[31] == adder_b[31]) & (sum[31] != i_req.op1[31]);
    assign eq       = sum[31:0] == 32'd0;
    assign lts      = sum[31] ^ overflow;
    assign ltu      = ~sum[32];

    assign shamt = i_req.op2[4:0];

    always_comb
    begin
        case (i_req.func.alu_op)
            rv_exec_pkg::alu_slt:  value = {31'd0, lts};
            rv_exec_pkg::alu_sltu: value = {31'd0, ltu};
            rv_exec_pkg::alu_xor:  value = i_req.op1 ^ i_req.op2;
            rv_exec_pkg::alu_or:   value = i_req.op1 | i_req.op2;
            rv_exec_pkg::alu_and:  value = i_req.op1 & i_req.op2;
            rv_exec_pkg::alu_sll:  value = i_req.op1 << shamt;
            rv_exec_pkg::alu_srl:  value = i_req.op1 >> shamt;
            rv_exec_pkg::alu_sra:  value = $unsigned($signed(i_req.op1) >>> shamt);
            default:               value = sum[31:0];
        endcase
    end

    always_comb
    begin
        case (i_req.func.cond)
            rv_exec_pkg::br_beq:  cond_met = eq;
            rv_exec_pkg::br_bne:  cond_met = ~eq;
            rv_exec_pkg::br_blt:  cond_met = lts;
            rv_exec_pkg::br_bge:  cond_met = ~lts;
            rv_exec_pkg::br_bltu: cond_met = ltu;
            rv_exec_pkg::br_bgeu: cond_met = ~ltu;
            default:              cond_met = 1'b0;
        endcase
    end

    assign o_res = '{
        value:     value,
        cond_true: is_branch & cond_met,
        sum:       sum[31:0]
    };

endmodule

//--- hdl/rv_exec_addr_unit.sv
`timescale 1ns/1ps

module rv_exec_addr_unit
(
    input  rv_exec_pkg::exec_req_t i_req,
    output rv_exec_pkg::addr_res_t o_res
);

    logic        is_jalr;
    logic        is_store;
    logic [31:0] pc_sum;
    logic [31:0] reg_sum;
    logic [31:0] target;
    logic [31:0] wdata;
    logic [3:0]  wsel;

    assign is_jalr  = i_req.op_class == rv_exec_pkg::class_jalr;
    assign is_store = i_req.op_class == rv_exec_pkg::class_store;

    assign pc_sum  = i_req.pc + i_req.imm;
    assign reg_sum = i_req.op1 + i_req.imm;

    // jalr drops bit 0 of the computed address.
    assign target = is_jalr ? {reg_sum[31:1], 1'b0} : pc_sum;

    always_comb
    begin
        case (i_req.func.size)
            rv_exec_pkg::size_byte: wdata = {4{i_req.store_data[7:0]}};
            rv_exec_pkg::size_half: wdata = {2{i_req.store_data[15:0]}};
            default:                wdata = i_req.store_data;
        endcase
    end

    // lanes follow the low address bits and only a store enables any.
    always_comb
    begin
        if (!is_store)
        begin
            wsel = 4'b0000;
        end
        else
        begin
            case (i_req.func.size)
                rv_exec_pkg::size_byte:
                begin
                    wsel = 4'b0001 << reg_sum[1:0];
                end
                rv_exec_pkg::size_half:
                begin
                    wsel = reg_sum[1] ? 4'b1100 : 4'b0011;
                end
                default:
                begin
                    wsel = 4'b1111;
                end
            endcase
        end
    end

    assign o_res = '{
        target:     target,
        store_addr: reg_sum,
        wdata:      wdata,
        wsel:       wsel
    };

endmodule

//--- hdl/rv_exec_merge.sv
`timescale 1ns/1ps

module rv_exec_merge
#(
    parameter int unsigned OUT_CREDITS = rv_exec_pkg::DEFAULT_OUT_CREDITS
)
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_flush,
    input  logic                    i_req_valid,
    input  rv_exec_pkg::exec_req_t  i_req,
    output logic [1:0]              o_issue_credit,
    output rv_exec_pkg::exec_req_t  o_slot_req,
    input  rv_exec_pkg::int_res_t   i_int,
    input  rv_exec_pkg::addr_res_t  i_addr,
    output logic                    o_resp_valid,
    output rv_exec_pkg::exec_resp_t o_resp,
    input  logic                    i_resp_credit,
    output rv_exec_pkg::redirect_t  o_redirect
);

    localparam int unsigned CREDIT_W = $clog2(OUT_CREDITS + 1);

    logic                    a_valid;
    rv_exec_pkg::exec_req_t  a_req;
    logic                    b_valid;
    rv_exec_pkg::exec_resp_t b_resp;
    rv_exec_pkg::redirect_t  redirect_q;
    logic [CREDIT_W-1:0]     credits;
    logic                    send;
    logic                    move;
    logic                    is_jump;
    logic                    taken;
    logic                    mispredict;
    logic [1:0]              flushed;

    assign send = b_valid & (credits != '0);
    assign move = a_valid & (~b_valid | send);

    assign is_jump    = (a_req.op_class == rv_exec_pkg::class_jal) |
                        (a_req.op_class == rv_exec_pkg::class_jalr);
    assign taken      = is_jump | ((a_req.op_class == rv_exec_pkg::class_branch) & i_int.cond_true);
    assign mispredict = taken ^ a_req.pred_taken;

    always_ff @(posedge i_clk)
    begin
        if (i_reset | i_flush)
        begin
            a_valid          <= 1'b0;
            b_valid          <= 1'b0;
            redirect_q.valid <= 1'b0;
        end
        else
        begin
            a_valid          <= i_req_valid | (a_valid & ~move);
            b_valid          <= move | (b_valid & ~send);
            redirect_q.valid <= move & mispredict;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_req_valid)
        begin
            a_req <= i_req;
        end
        if (move)
        begin
            b_resp.result    <= is_jump ? a_req.pc_next : i_int.value;
            b_resp.rd        <= a_req.rd;
            b_resp.reg_write <= a_req.reg_write;
            b_resp.store     <= a_req.op_class == rv_exec_pkg::class_store;
            b_resp.addr      <= i_addr.store_addr;
            b_resp.wdata     <= i_addr.wdata;
            b_resp.wsel      <= i_addr.wsel;
            redirect_q.pc    <= taken ? i_addr.target : a_req.pc_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            credits <= CREDIT_W'(OUT_CREDITS);
        end
        else
        begin
            credits <= credits - CREDIT_W'(send) + CREDIT_W'(i_resp_credit);
        end
    end

    // a flush also drops a request arriving in the same cycle, so its slot comes back.
    assign flushed = i_flush ? (2'(a_valid) + 2'(b_valid & ~send) + 2'(i_req_valid)) : 2'd0;
    assign o_issue_credit = 2'(send) + flushed;

    assign o_slot_req   = a_req;
    assign o_resp_valid = send;
    assign o_resp       = b_resp;
    assign o_redirect   = redirect_q;

    // the issuer only sends while it holds a credit, so a full stage never sees a request.
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_req_valid |-> !(a_valid && b_valid));

    assert property (@(posedge i_clk) disable iff (i_reset)
        credits <= CREDIT_W'(OUT_CREDITS));

endmodule

//--- hdl/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top
#(
    parameter int unsigned OUT_CREDITS = rv_exec_pkg::DEFAULT_OUT_CREDITS
)
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_flush,
    input  logic                    i_req_valid,
    input  rv_exec_pkg::exec_req_t  i_req,
    output logic [1:0]              o_issue_credit,
    output logic                    o_resp_valid,
    output rv_exec_pkg::exec_resp_t o_resp,
    input  logic                    i_resp_credit,
    output rv_exec_pkg::redirect_t  o_redirect
);

    rv_exec_pkg::exec_req_t  slot_req;
    rv_exec_pkg::int_res_t   int_res;
    rv_exec_pkg::addr_res_t  addr_res;

    rv_exec_merge
    #(
        .OUT_CREDITS    (OUT_CREDITS)
    )
    u_merge
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_flush        (i_flush),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_issue_credit (o_issue_credit),
        .o_slot_req     (slot_req),
        .i_int          (int_res),
        .i_addr         (addr_res),
        .o_resp_valid   (o_resp_valid),
        .o_resp         (o_resp),
        .i_resp_credit  (i_resp_credit),
        .o_redirect     (o_redirect)
    );

    // both units work side by side on the packet held in slot A.
    rv_exec_int_unit u_int
    (
        .i_req          (slot_req),
        .o_res          (int_res)
    );

    rv_exec_addr_unit u_addr
    (
        .i_req          (slot_req),
        .o_res          (addr_res)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int RESET_CYCLES = 3
)
(
    output logic o_clk,
    output logic o_reset
);

    // 8 ns period.
    initial
    begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

//--- verification/tb_rv_exec.sv
`timescale 1ns/1ps

module tb_rv_exec;

    localparam int OUT_CREDITS    = 4;
    localparam int N_ALU          = 400;
    localparam int N_CTRL         = 300;
    localparam int N_STORE        = 200;
    localparam int N_BACKPRESSURE = 200;
    localparam int N_FLUSH        = 300;
    // a request can wait behind a full credit hold and the release after it.
    localparam int WORST_DELAY    = 128;
    localparam int TIMEOUT_CYCLES =
        (N_ALU + N_CTRL + N_STORE + N_BACKPRESSURE + N_FLUSH) * WORST_DELAY;

    typedef struct packed
    {
        rv_exec_pkg::exec_resp_t resp;
        rv_exec_pkg::exec_resp_t mask;
        logic                    mispredict;
        logic [31:0]             redirect_pc;
        logic                    redirect_seen;
    } expect_t;

    logic                    clk;
    logic                    reset;
    logic                    flush;
    logic                    req_valid;
    rv_exec_pkg::exec_req_t  req;
    logic [1:0]              issue_credit;
    logic                    resp_valid;
    rv_exec_pkg::exec_resp_t resp;
    logic                    resp_credit;
    rv_exec_pkg::redirect_t  redirect;

    expect_t     model_q[$];
    logic [15:0] lfsr_state;
    int          n_checks;
    int          n_errors;
    int          n_flushes;
    int          cycles;
    int          issuer_credits;
    int          down_credits;
    int          pending_returns;
    int          mix;
    int          issued;
    int          hold_left;
    bit          issuing;
    bit          hold_mode;
    bit          flush_mode;
    bit          holding;

    tb_clock_gen u_clock_gen
    (
        .o_clk   (clk),
        .o_reset (reset)
    );

    rv_exec_top
    #(
        .OUT_CREDITS    (OUT_CREDITS)
    )
    i_dut
    (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_flush        (flush),
        .i_req_valid    (req_valid),
        .i_req          (req),
        .o_issue_credit (issue_credit),
        .o_resp_valid   (resp_valid),
        .o_resp         (resp),
        .i_resp_credit  (resp_credit),
        .o_redirect     (redirect)
    );

    // x^16 + x^14 + x^13 + x^11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // one operand in four is a corner value for compares and shifts.
    function automatic logic [31:0] edge_operand();
        logic [31:0] v;
        if (rand_bits(2) != 0)
            v = rand_bits(32);
        else
            case (rand_bits(3))
                0:       v = 32'h0000_0000;
                1:       v = 32'h0000_0001;
                2:       v = 32'h7fff_ffff;
                3:       v = 32'h8000_0000;
                4:       v = 32'hffff_ffff;
                5:       v = 32'h0000_001f;
                6:       v = 32'h0000_0020;
                default: v = 32'hffff_fffe;
            endcase
        return v;
    endfunction

    function automatic rv_exec_pkg::exec_req_t make_req(input int kind);
        rv_exec_pkg::exec_req_t r;
        int                     pick;
        int                     sel;
        logic [11:0]            imm12;
        r = '0;
        pick = (kind == 3) ? int'(rand_bits(2) % 3) : kind;
        r.op1 = edge_operand();
        r.op2 = (rand_bits(3) == 0) ? r.op1 : edge_operand();
        r.store_data = rand_bits(32);
        r.pc = rand_bits(30) << 2;
        r.pc_next = r.pc + 32'd4;
        imm12 = 12'(rand_bits(12));
        r.imm = {{20{imm12[11]}}, imm12};
        r.rd = 5'(rand_bits(5));
        r.reg_write = rand_bits(1) != 0;
        r.pred_taken = rand_bits(1) != 0;
        if (pick == 0)
        begin
            r.op_class = rv_exec_pkg::class_alu;
            r.func.alu_op = rv_exec_pkg::alu_op_t'(4'(rand_bits(4) % 10));
        end
        else if (pick == 1)
        begin
            sel = int'(rand_bits(2));
            if (sel == 0)
                r.op_class = rv_exec_pkg::class_jal;
            else if (sel == 1)
                r.op_class = rv_exec_pkg::class_jalr;
            else
            begin
                r.op_class = rv_exec_pkg::class_branch;
                case (rand_bits(3) % 6)
                    0:       r.func.cond = rv_exec_pkg::br_beq;
                    1:       r.func.cond = rv_exec_pkg::br_bne;
                    2:       r.func.cond = rv_exec_pkg::br_blt;
                    3:       r.func.cond = rv_exec_pkg::br_bge;
                    4:       r.func.cond = rv_exec_pkg::br_bltu;
                    default: r.func.cond = rv_exec_pkg::br_bgeu;
                endcase
            end
        end
        else
        begin
            r.op_class = rv_exec_pkg::class_store;
            r.func.size = rv_exec_pkg::store_size_t'(4'(rand_bits(2) % 3));
        end
        return r;
    endfunction

    function automatic logic [31:0] alu_model(input rv_exec_pkg::alu_op_t op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            rv_exec_pkg::alu_sub:  return a - b;
            rv_exec_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_exec_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            rv_exec_pkg::alu_xor:  return a ^ b;
            rv_exec_pkg::alu_or:   return a | b;
            rv_exec_pkg::alu_and:  return a & b;
            rv_exec_pkg::alu_sll:  return a << b[4:0];
            rv_exec_pkg::alu_srl:  return a >> b[4:0];
            rv_exec_pkg::alu_sra:  return 32'($signed(a) >>> b[4:0]);
            default:               return a + b;
        endcase
    endfunction

    function automatic logic branch_model(input rv_exec_pkg::branch_cond_t cond,
                                          input logic [31:0] a, input logic [31:0] b);
        case (cond)
            rv_exec_pkg::br_beq:  return a == b;
            rv_exec_pkg::br_bne:  return a != b;
            rv_exec_pkg::br_blt:  return $signed(a) < $signed(b);
            rv_exec_pkg::br_bge:  return $signed(a) >= $signed(b);
            rv_exec_pkg::br_bltu: return a < b;
            default:              return a >= b;
        endcase
    endfunction

    // result is only defined for ALU operations and jumps, lanes only for stores.
    function automatic expect_t build_expect(input rv_exec_pkg::exec_req_t r);
        expect_t     e;
        logic [31:0] addr;
        logic [31:0] target;
        logic        taken;
        int          lane;
        e = '0;
        e.mask = '1;
        addr = r.op1 + r.imm;
        e.resp.rd = r.rd;
        e.resp.reg_write = r.reg_write;
        e.resp.store = r.op_class == rv_exec_pkg::class_store;
        e.resp.addr = addr;
        // each byte lane gets its data and its enable from the access size.
        for (lane = 0; lane < 4; lane++)
        begin
            if (r.func.size == rv_exec_pkg::size_byte)
            begin
                e.resp.wdata[8*lane +: 8] = r.store_data[7:0];
                e.resp.wsel[lane] = lane == int'(addr[1:0]);
            end
            else if (r.func.size == rv_exec_pkg::size_half)
            begin
                e.resp.wdata[8*lane +: 8] = r.store_data[8*(lane%2) +: 8];
                e.resp.wsel[lane] = (lane / 2) == int'(addr[1]);
            end
            else
            begin
                e.resp.wdata[8*lane +: 8] = r.store_data[8*lane +: 8];
                e.resp.wsel[lane] = 1'b1;
            end
        end
        if (!e.resp.store)
        begin
            e.mask.addr = '0;
            e.mask.wdata = '0;
            e.mask.wsel = '0;
        end
        taken = (r.op_class == rv_exec_pkg::class_jal) || (r.op_class == rv_exec_pkg::class_jalr) ||
                (r.op_class == rv_exec_pkg::class_branch && branch_model(r.func.cond, r.op1, r.op2));
        target = (r.op_class == rv_exec_pkg::class_jalr) ? (addr & ~32'd1) : (r.pc + r.imm);
        if (r.op_class == rv_exec_pkg::class_alu)
            e.resp.result = alu_model(r.func.alu_op, r.op1, r.op2);
        else if (taken && r.op_class != rv_exec_pkg::class_branch)
            e.resp.result = r.pc_next;
        else
            e.mask.result = '0;
        e.mispredict = taken ^ r.pred_taken;
        e.redirect_pc = taken ? target : r.pc_next;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        n_checks++;
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic confirm(input bit ok, input string what);
        n_checks++;
        assert (ok)
        else
        begin
            $display("error at %0t: %s", $time, what);
            n_errors++;
        end
    endtask

    // sample what the DUT did in the cycle that just ended, then drive the next one.
    task automatic cycle_step();
        expect_t                e;
        rv_exec_pkg::exec_req_t r;
        @(posedge clk);
        if (redirect.valid)
        begin
            confirm(model_q.size() != 0, "redirect with no packet in the stage");
            if (model_q.size() != 0)
            begin
                e = model_q[0];
                confirm(e.mispredict && !e.redirect_seen, "redirect for a correctly predicted packet");
                check_value("o_redirect.pc", 128'(redirect.pc), 128'(e.redirect_pc));
                e.redirect_seen = 1'b1;
                model_q[0] = e;
            end
        end
        if (resp_valid)
        begin
            confirm(down_credits > 0, "o_resp_valid while no downstream credit was left");
            down_credits--;
            pending_returns++;
            confirm(model_q.size() != 0, "response with no packet in the stage");
            if (model_q.size() != 0)
            begin
                e = model_q.pop_front();
                check_value("o_resp", 128'(resp & e.mask), 128'(e.resp & e.mask));
                check_value("o_redirect.valid", 128'(e.redirect_seen), 128'(e.mispredict));
            end
        end
        if (resp_credit)
            down_credits++;
        issuer_credits += int'(issue_credit);
        if (flush)
            model_q.delete();
        confirm(issuer_credits + model_q.size() == 2, "issuer credits out of step with the stage");

        if (!hold_mode)
            holding = 1'b0;
        else if (hold_left == 0)
        begin
            holding = !holding;
            hold_left = int'(rand_bits(6));
        end
        else
            hold_left--;
        if (pending_returns > 0 && !holding && rand_bits(1) != 0)
        begin
            resp_credit <= 1'b1;
            pending_returns--;
        end
        else
            resp_credit <= 1'b0;
        if (issuing && issuer_credits > 0 && rand_bits(2) != 0)
        begin
            r = make_req(mix);
            req <= r;
            req_valid <= 1'b1;
            model_q.push_back(build_expect(r));
            issuer_credits--;
            issued++;
        end
        else
            req_valid <= 1'b0;
        if (flush_mode && rand_bits(4) == 0)
        begin
            flush <= 1'b1;
            n_flushes++;
        end
        else
            flush <= 1'b0;
    endtask

    task automatic run_test(input int num, input string name, input int kind, input int count,
                            input bit hold_en, input bit flush_en);
        int errors_before;
        int checks_before;
        int flushes_before;
        errors_before = n_errors;
        checks_before = n_checks;
        flushes_before = n_flushes;
        mix = kind;
        hold_mode = hold_en;
        flush_mode = flush_en;
        issued = 0;
        issuing = 1'b1;
        while (issued < count)
            cycle_step();
        issuing = 1'b0;
        hold_mode = 1'b0;
        flush_mode = 1'b0;
        // drain until every packet has left and every credit is back home.
        while (model_q.size() != 0 || issuer_credits != 2 || pending_returns != 0 ||
               down_credits != OUT_CREDITS)
            cycle_step();
        $display("test %0d %s: %0d requests, %0d flushes, %0d checks, %0d errors", num, name,
                 count, n_flushes - flushes_before, n_checks - checks_before,
                 n_errors - errors_before);
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        req_valid = 1'b0;
        req = '0;
        flush = 1'b0;
        resp_credit = 1'b0;
        lfsr_state = 16'd19788;
        n_checks = 0;
        n_errors = 0;
        n_flushes = 0;
        issuer_credits = 2;
        down_credits = OUT_CREDITS;
        pending_returns = 0;
        hold_left = 0;
        holding = 1'b0;
        issuing = 1'b0;
        hold_mode = 1'b0;
        flush_mode = 1'b0;
        @(posedge clk);
        while (reset)
            @(posedge clk);
        confirm(!resp_valid && !redirect.valid && issue_credit == 2'd0,
                "outputs are not idle after reset");
        run_test(1, "alu operations", 0, N_ALU, 1'b0, 1'b0);
        run_test(2, "branches and jumps", 1, N_CTRL, 1'b0, 1'b0);
        run_test(3, "stores", 2, N_STORE, 1'b0, 1'b0);
        run_test(4, "back-pressure", 3, N_BACKPRESSURE, 1'b1, 1'b0);
        run_test(5, "flush", 3, N_FLUSH, 1'b0, 1'b1);
        $display("summary: %0d checks, %0d errors, %0d cycles", n_checks, n_errors, cycles);
        if (n_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- rv_exec.f
hdl/rv_exec_pkg.sv
hdl/rv_exec_int_unit.sv
hdl/rv_exec_addr_unit.sv
hdl/rv_exec_merge.sv
hdl/rv_exec_top.sv
verification/tb_clock_gen.sv
verification/tb_rv_exec.sv

//--- Makefile
# Verilator build and run for the rv_exec testbench.
VERILATOR  ?= verilator
TOP        ?= tb_rv_exec
FILELIST   ?= rv_exec.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
PASS_TEXT  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only if the pass line shows up in the simulator output.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
